/* logic/alu.sv */
module alu import alu_pkg::*; (
	input  data_t      a_i,      // Operand A, from rs
	input  data_t      b_i,      // Operand B, from rt
	input  alu_op_e    op_i,     // Operation select
	output data_t      result_o, // Result word
	output alu_flags_t flags_o   // LT and ZF
);

	logic  do_sub;    // Adder runs A - B
	data_t cla_b;     // Adder B input
	logic  cla_ci;    // Adder carry in
	data_t cla_sum;   // Sum or difference
	logic  cla_co;    // Adder carry out
	data_t shift_out; // Shifter result
	data_t flip;      // A bit reversed
	logic  ovf;       // Signed overflow of A - B
	logic  lt_s;      // Signed A < B
	logic  eq;        // A == B
	data_t res;       // Selected result
	logic  lt;        // LT flag before packing

	// Subtract and compares share the inverted-B path
	assign do_sub = (op_i == OP_SUB) || (op_i == OP_SEQ) ||
		(op_i == OP_SLT) || (op_i == OP_SLE);
	assign cla_b  = do_sub ? ~b_i : b_i;  // Two's complement of B with ci
	assign cla_ci = do_sub;

	alu_cla u_cla (
		.a_i   (a_i),
		.b_i   (cla_b),
		.c_i   (cla_ci),
		.sum_o (cla_sum),
		.c_o   (cla_co)
	);

	alu_shifter u_shifter (
		.in_i   (a_i),
		.cnt_i  (b_i[3:0]),                  // Upper bits of B ignored
		.mode_i (shift_mode_e'(op_i[1:0])),  // Low opcode bits pick the mode
		.out_o  (shift_out)
	);

	// Overflow only when signs differ and the difference flips sign from A
	assign ovf  = (a_i[DATA_W-1] != b_i[DATA_W-1]) &&
		(cla_sum[DATA_W-1] != a_i[DATA_W-1]);
	assign lt_s = cla_sum[DATA_W-1] ^ ovf;  // True sign of A - B
	assign eq   = (cla_sum == '0);          // Zero difference

	assign flip = {<<{a_i}};  // Reverse bit order

	always_comb begin
		res = '0;  // OP_NONE and anything unlisted
		lt  = 1'b0;
		case (op_i)
			OP_ADD, OP_SUB: begin
				res = cla_sum;
			end
			OP_XOR:   res = a_i ^ b_i;
			OP_ANDN:  res = a_i & ~b_i;
			OP_ROL, OP_SLL, OP_ROR, OP_SRL: begin
				res = shift_out;
			end
			OP_SEQ:   res = data_t'(eq);
			OP_SLT: begin
				res = data_t'(lt_s);
				lt  = lt_s;
			end
			OP_SLE: begin
				res = data_t'(lt_s | eq);
				lt  = lt_s;  // Strict less than, even for SLE
			end
			OP_SCO:   res = data_t'(cla_co);  // Carry of plain A + B
			OP_FLIP:  res = flip;
			OP_PASSB: res = b_i;
			OP_SLBI:  res = {a_i[7:0], b_i[7:0]};
			default:  res = '0;
		endcase
	end

	assign result_o = res;
	assign flags_o  = '{lt: lt, zf: (res == '0)};  // ZF from the chosen word

endmodule

/* logic/alu_cla.sv */
module alu_cla import alu_pkg::*; (
	input  data_t a_i,   // Addend A
	input  data_t b_i,   // Addend B, already inverted for subtract
	input  logic  c_i,   // Carry in
	output data_t sum_o, // Sum
	output logic  c_o    // Carry out of bit 15
);

	data_t      bit_g;  // Per-bit generate
	data_t      bit_p;  // Per-bit propagate
	data_t      carry;  // Carry into each bit
	logic [3:0] grp_g;  // Group generate
	logic [3:0] grp_p;  // Group propagate
	logic [3:0] grp_c;  // Carry into each group

	assign bit_g = a_i & b_i;
	assign bit_p = a_i ^ b_i;

	// First level, lookahead inside each nibble
	for (genvar i = 0; i < 4; i++) begin : g_grp
		logic [3:0] g;  // Nibble slice of generate
		logic [3:0] p;  // Nibble slice of propagate
		logic       ci; // Group carry in

		assign g  = bit_g[4*i +: 4];
		assign p  = bit_p[4*i +: 4];
		assign ci = grp_c[i];

		assign carry[4*i]   = ci;
		assign carry[4*i+1] = g[0] | (p[0] & ci);
		assign carry[4*i+2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & ci);
		assign carry[4*i+3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) |
			(p[2] & p[1] & p[0] & ci);

		assign grp_g[i] = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1]) |
			(p[3] & p[2] & p[1] & g[0]);  // Nibble generates a carry
		assign grp_p[i] = &p;             // Nibble passes carry through
	end

	// Second level, carries between nibbles
	assign grp_c[0] = c_i;
	assign grp_c[1] = grp_g[0] | (grp_p[0] & c_i);
	assign grp_c[2] = grp_g[1] | (grp_p[1] & grp_g[0]) | (grp_p[1] & grp_p[0] & c_i);
	assign grp_c[3] = grp_g[2] | (grp_p[2] & grp_g[1]) | (grp_p[2] & grp_p[1] & grp_g[0]) |
		(grp_p[2] & grp_p[1] & grp_p[0] & c_i);

	assign c_o = grp_g[3] | (grp_p[3] & grp_g[2]) | (grp_p[3] & grp_p[2] & grp_g[1]) |
		(grp_p[3] & grp_p[2] & grp_p[1] & grp_g[0]) |
		(grp_p[3] & grp_p[2] & grp_p[1] & grp_p[0] & c_i);  // Out of top nibble

	assign sum_o = bit_p ^ carry;

endmodule

/* logic/alu_pkg.sv */
package alu_pkg;

	localparam int DATA_W = 16;  // Datapath width
	localparam int REG_N  = 8;   // Register count
	localparam int REG_AW = 3;   // Register index width

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [REG_AW-1:0] reg_idx_t;

	// ALU operations, encoding matches the opcode field
	typedef enum logic [3:0] {
		OP_ADD   = 4'd0,   // A + B
		OP_SUB   = 4'd1,   // A - B
		OP_XOR   = 4'd2,   // A ^ B
		OP_ANDN  = 4'd3,   // A & ~B
		OP_ROL   = 4'd4,   // Rotate left by B[3:0]
		OP_SLL   = 4'd5,   // Logical left by B[3:0]
		OP_ROR   = 4'd6,   // Rotate right by B[3:0]
		OP_SRL   = 4'd7,   // Logical right by B[3:0]
		OP_SEQ   = 4'd8,   // A == B
		OP_SLT   = 4'd9,   // Signed A < B
		OP_SLE   = 4'd10,  // Signed A <= B
		OP_SCO   = 4'd11,  // Carry out of A + B
		OP_FLIP  = 4'd12,  // Bit reverse of A
		OP_PASSB = 4'd13,  // B unchanged
		OP_SLBI  = 4'd14,  // {A[7:0], B[7:0]}
		OP_NONE  = 4'd15   // Zero result
	} alu_op_e;

	// Shifter mode, low two opcode bits of the shift group
	typedef enum logic [1:0] {
		SH_ROL = 2'd0,  // Left, wrap
		SH_SLL = 2'd1,  // Left, zero fill
		SH_ROR = 2'd2,  // Right, wrap
		SH_SRL = 2'd3   // Right, zero fill
	} shift_mode_e;

	// Status bits out of the ALU
	typedef struct packed {
		logic lt;  // Signed less than, compares only
		logic zf;  // Result is zero
	} alu_flags_t;

	// One issued operation
	typedef struct packed {
		alu_op_e  op;  // Operation
		reg_idx_t rd;  // Destination
		reg_idx_t rs;  // Operand A source
		reg_idx_t rt;  // Operand B source
	} exec_req_t;

endpackage

/* logic/alu_shifter.sv */
module alu_shifter import alu_pkg::*; (
	input  data_t       in_i,   // Value to shift
	input  logic [3:0]  cnt_i,  // Amount, 0 to 15
	input  shift_mode_e mode_i, // Direction and fill
	output data_t       out_o   // Shifted value
);

	data_t stg [0:4];  // Stage outputs, stg[0] is the input
	logic  right;      // Shift toward bit 0
	logic  zero_fill;  // Logical shift, no wrap

	assign right     = (mode_i == SH_ROR) || (mode_i == SH_SRL);
	assign zero_fill = (mode_i == SH_SLL) || (mode_i == SH_SRL);

	assign stg[0] = in_i;

	// Stage s moves by 2**s when cnt_i[s] is set
	for (genvar s = 0; s < 4; s++) begin : g_stage
		data_t sh_l;   // Left, vacated bits zero
		data_t sh_r;   // Right, vacated bits zero
		data_t wrap_l; // Bits that fall off the top
		data_t wrap_r; // Bits that fall off the bottom
		data_t moved;  // Stage result when enabled

		assign sh_l   = stg[s] << (2**s);
		assign sh_r   = stg[s] >> (2**s);
		assign wrap_l = stg[s] >> (DATA_W - 2**s);  // Reinserted at the bottom
		assign wrap_r = stg[s] << (DATA_W - 2**s);  // Reinserted at the top

		always_comb begin
			if (right) begin
				moved = zero_fill ? sh_r : (sh_r | wrap_r);
			end else begin
				moved = zero_fill ? sh_l : (sh_l | wrap_l);
			end
		end

		assign stg[s+1] = cnt_i[s] ? moved : stg[s];  // Bypass when bit clear
	end

	assign out_o = stg[4];

endmodule

/* logic/exec_unit.sv */
module exec_unit import alu_pkg::*; (
	input  logic       clk,
	input  logic       reset_i,     // Sync, active high
	input  logic       issue_i,     // One-cycle issue strobe
	input  exec_req_t  req_i,       // Op and register indices
	input  logic       load_i,      // One-cycle load strobe
	input  reg_idx_t   load_rd_i,   // Load destination
	input  data_t      load_data_i, // Load value
	output data_t      result_o,    // Last issue result
	output alu_flags_t flags_o,     // Last issue flags
	output logic       done_o       // Pulses the cycle after issue
);

	data_t      rs_data;  // Operand A
	data_t      rt_data;  // Operand B
	data_t      alu_res;  // ALU result, combinational
	alu_flags_t alu_flg;  // ALU flags, combinational
	logic       wr_en;    // Write port enable
	reg_idx_t   wr_idx;   // Write port index
	data_t      wr_data;  // Write port data

	// Load takes the port if both ever arrive together
	assign wr_en   = issue_i | load_i;
	assign wr_idx  = load_i ? load_rd_i : req_i.rd;
	assign wr_data = load_i ? load_data_i : alu_res;

	reg_file u_reg_file (
		.clk       (clk),
		.reset_i   (reset_i),
		.rs_i      (req_i.rs),
		.rt_i      (req_i.rt),
		.rs_data_o (rs_data),
		.rt_data_o (rt_data),
		.we_i      (wr_en),
		.wr_idx_i  (wr_idx),
		.wr_data_i (wr_data)
	);

	alu u_alu (
		.a_i      (rs_data),
		.b_i      (rt_data),
		.op_i     (req_i.op),
		.result_o (alu_res),
		.flags_o  (alu_flg)
	);

	// Output registers update at the same edge as the rd write
	always_ff @(posedge clk) begin
		if (reset_i) begin
			done_o   <= 1'b0;
			result_o <= '0;
			flags_o  <= '0;
		end else begin
			done_o <= issue_i;  // Loads never raise done
			if (issue_i) begin
				result_o <= alu_res;
				flags_o  <= alu_flg;
			end
		end
	end

endmodule

/* logic/reg_file.sv */
module reg_file import alu_pkg::*; (
	input  logic     clk,
	input  logic     reset_i,   // Clears every register
	input  reg_idx_t rs_i,      // Read port A index
	input  reg_idx_t rt_i,      // Read port B index
	output data_t    rs_data_o, // Read port A data
	output data_t    rt_data_o, // Read port B data
	input  logic     we_i,      // Write enable
	input  reg_idx_t wr_idx_i,  // Write index
	input  data_t    wr_data_i  // Write data
);

	data_t regs [REG_N];  // Register storage

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < REG_N; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i) begin
			regs[wr_idx_i] <= wr_data_i;  // Visible to reads after the edge
		end
	end

	// Both reads are plain muxes, no clock
	assign rs_data_o = regs[rs_i];
	assign rt_data_o = regs[rt_i];

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the exec_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module exec_unit_tb -f sim.f -o exec_unit_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/exec_unit_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit "$status"
fi

exit 0

/* sim.f */
logic/alu_pkg.sv
logic/alu_cla.sv
logic/alu_shifter.sv
logic/alu.sv
logic/reg_file.sv
logic/exec_unit.sv
tests/exec_unit_props.sv
tests/exec_unit_tb.sv

/* tests/exec_cases.txt */
# L rd value_hex                            load one register
# X name op rd rs rt result_hex lt zf       issue one op, A from rs, B from rt
X reset_regs 0 7 0 1 0000 0 1
L 0 1234
L 1 00ff
L 2 ffff
L 3 0001
L 4 8000
L 5 7fff
L 6 f0f0
X add_basic 0 7 0 1 1333 0 0
X add_wrap 0 7 2 3 0000 0 1
X sub_basic 1 7 0 1 1135 0 0
X sub_wrap 1 7 3 2 0002 0 0
X sub_equal 1 7 0 0 0000 0 1
X sco_carry 11 7 2 3 0001 0 0
X sco_clear 11 7 0 1 0000 0 1
X xor_mix 2 7 0 6 e2c4 0 0
X andn_mix 3 7 0 6 0204 0 0
X flip_a 12 7 0 6 2c48 0 0
X passb_b 13 7 0 6 f0f0 0 0
X slbi_bytes 14 7 0 6 34f0 0 0
L 6 a5c8
X rol_by0 4 7 0 4 1234 0 0
X rol_by1_wrap 4 7 4 3 0001 0 0
X rol_by8 4 7 0 6 3412 0 0
X rol_by15 4 7 0 1 091a 0 0
X sll_by1_out 5 7 4 3 0000 0 1
X sll_by15 5 7 3 1 8000 0 0
X ror_by1_wrap 6 7 3 3 8000 0 0
X ror_by8 6 7 0 6 3412 0 0
X srl_by8 7 7 0 6 0012 0 0
X srl_by15 7 7 4 5 0001 0 0
X seq_equal 8 7 0 0 0001 0 0
X seq_diff 8 7 4 5 0000 0 1
X slt_ovf 9 7 4 5 0001 1 0
X slt_ovf_rev 9 7 5 4 0000 0 1
X slt_mixed 9 7 2 3 0001 1 0
X sle_equal 10 7 4 4 0001 0 0
X sle_ovf 10 7 5 4 0000 0 1
X none_zero 15 7 0 1 0000 0 1
X dep_first 0 6 0 3 1235 0 0
X dep_second 0 7 6 3 1236 0 0
X dep_third 1 6 6 6 0000 0 1

/* tests/exec_unit_props.sv */
module exec_unit_props (
	input logic clk,
	input logic reset_i,
	input logic issue_i,
	input logic load_i,
	input logic done_i
);

	// Both strobes would fight over the one write port
	strobe_excl: assert property (@(posedge clk) disable iff (reset_i)
		!(issue_i && load_i))
		else $error("issue_i and load_i high in the same cycle");

	// Issue sampled at one edge, done seen at the next
	done_after_issue: assert property (@(posedge clk) disable iff (reset_i)
		issue_i |=> done_i)
		else $error("done_o missing one cycle after issue_i");

	done_only_issue: assert property (@(posedge clk) disable iff (reset_i)
		!issue_i |=> !done_i)
		else $error("done_o high without an issue one cycle earlier");

	done_low_after_reset: assert property (@(posedge clk) reset_i |=> !done_i)
		else $error("done_o high in the cycle after reset");

endmodule

bind exec_unit exec_unit_props u_props (
	.clk     (clk),
	.reset_i (reset_i),
	.issue_i (issue_i),
	.load_i  (load_i),
	.done_i  (done_o)
);

/* tests/exec_unit_tb.sv */
module exec_unit_tb import alu_pkg::*; ();

	logic       clk;
	logic       reset_i;
	logic       issue_i;
	exec_req_t  req_i;
	logic       load_i;
	reg_idx_t   load_rd_i;
	data_t      load_data_i;
	data_t      result_o;
	alu_flags_t flags_o;
	logic       done_o;

	int         cycle_limit = 20;  // Raised once the cases file is sized
	int         cycles      = 0;   // Clock edges since start
	int         issued      = 0;   // Issue steps driven
	int         checked     = 0;   // done_o pulses compared
	string      exp_name_q[$];     // Case names waiting for done
	data_t      exp_word_q[$];     // Expected result words
	alu_flags_t exp_flag_q[$];     // Expected flags

	exec_unit UUT (
		.clk         (clk),
		.reset_i     (reset_i),
		.issue_i     (issue_i),
		.req_i       (req_i),
		.load_i      (load_i),
		.load_rd_i   (load_rd_i),
		.load_data_i (load_data_i),
		.result_o    (result_o),
		.flags_o     (flags_o),
		.done_o      (done_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;  // Period 100
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "run stopped at cycle %0d", cycles);
	endtask

	task automatic check_word(input string name, input data_t exp, input data_t act);
		if (act !== exp) begin
			abort_run($sformatf("Mismatch %s result: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic check_flags(input string name, input alu_flags_t exp, input alu_flags_t act);
		if (act !== exp) begin
			abort_run($sformatf("Mismatch %s flags: expected lt=%b zf=%b, actual lt=%b zf=%b",
				name, exp.lt, exp.zf, act.lt, act.zf));
		end
	endtask

	task automatic open_cases(output int fd);
		fd = $fopen("tests/exec_cases.txt", "r");
		if (fd == 0) begin
			abort_run("Cannot open tests/exec_cases.txt for reading");
		end
	endtask

	// Run limit counted in rising edges
	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			abort_run($sformatf("Timeout, done never arrived within %0d cycles", cycle_limit));
		end
	end

	// Outputs are stable at the falling edge
	always @(negedge clk) begin : check_done
		string      name;
		data_t      word;
		alu_flags_t flg;
		if (done_o) begin
			if (exp_name_q.size() == 0) begin
				abort_run("done_o pulsed with no issue outstanding");
			end else begin
				name = exp_name_q.pop_front();
				word = exp_word_q.pop_front();
				flg  = exp_flag_q.pop_front();
				check_word(name, word, result_o);
				check_flags(name, flg, flags_o);
				checked++;  // One pulse per issue
			end
		end
	end

	initial begin : run_cases
		int          fd;
		int          n_lines;
		int          n;
		string       line;
		string       kind;
		string       name;
		int          op;
		int          rd;
		int          rs;
		int          rt;
		int unsigned val;
		int          lt;
		int          zf;
		exec_req_t   req;
		alu_flags_t  flg;

		reset_i     = 1'b1;
		issue_i     = 1'b0;
		req_i       = '0;
		load_i      = 1'b0;
		load_rd_i   = '0;
		load_data_i = '0;

		n_lines = 0;
		open_cases(fd);
		while ($fgets(line, fd) != 0) begin
			n_lines++;
		end
		$fclose(fd);
		cycle_limit = 4 * n_lines + 20;  // Each step takes one cycle so this leaves slack

		repeat (3) @(posedge clk);
		reset_i <= 1'b0;
		@(negedge clk);
		check_word("after_reset", '0, result_o);
		check_flags("after_reset", '0, flags_o);

		open_cases(fd);
		while ($fgets(line, fd) != 0) begin
			n = $sscanf(line, "%s", kind);
			if (n != 1 || line.getc(0) == "#") begin
				continue;  // Blank or comment
			end
			if (kind == "L") begin
				n = $sscanf(line, "%s %d %h", kind, rd, val);
				if (n != 3) begin
					abort_run({"Malformed load line in cases file: ", line});
				end
				@(posedge clk);
				issue_i     <= 1'b0;
				load_i      <= 1'b1;
				load_rd_i   <= reg_idx_t'(rd);
				load_data_i <= data_t'(val);
			end else if (kind == "X") begin
				n = $sscanf(line, "%s %s %d %d %d %d %h %d %d",
					kind, name, op, rd, rs, rt, val, lt, zf);
				if (n != 9) begin
					abort_run({"Malformed issue line in cases file: ", line});
				end
				req.op = alu_op_e'(op[3:0]);
				req.rd = reg_idx_t'(rd);
				req.rs = reg_idx_t'(rs);
				req.rt = reg_idx_t'(rt);
				flg.lt = lt[0];
				flg.zf = zf[0];
				@(posedge clk);
				load_i  <= 1'b0;
				issue_i <= 1'b1;
				req_i   <= req;
				exp_name_q.push_back(name);
				exp_word_q.push_back(data_t'(val));
				exp_flag_q.push_back(flg);
				issued++;
			end else begin
				abort_run({"Unknown step kind in cases file: ", kind});
			end
		end
		$fclose(fd);

		@(posedge clk);
		issue_i <= 1'b0;
		load_i  <= 1'b0;
		while (checked != issued) begin
			@(posedge clk);  // Timeout counter bounds this
		end
		@(negedge clk);  // done_o must stay low after the last check
		@(posedge clk);

		if (issued > 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			abort_run("Cases file held no issue steps");
		end
	end

endmodule
